//--- src/exe_pkg.sv
// --------------------------------------
// Execute stage package
// Widths, opcode and select enums, and the size of the pipe word
// --------------------------------------
package exe_pkg;

   localparam int XLEN    = 32;                   // Register and data width
   localparam int PC_SZ   = 32;                   // Program counter width
   localparam int REG_ASZ = 5;                    // Register address width
   localparam int OP_SZ   = 4;                    // Decode op field, big enough for alu_op_e

   // Instruction groups coming from decode
   typedef enum logic [2:0] {
      IG_ALU,
      IG_BR,
      IG_LD,
      IG_ST,
      IG_ILL
   } ig_type_e;

   typedef enum logic [3:0] {
      ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU
   } alu_op_e;

   typedef enum logic [2:0] {
      BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR
   } br_op_e;

   typedef enum logic [1:0] {X_RS1, X_PC, X_ZERO} x_sel_e;   // ALU X operand
   typedef enum logic       {Y_RS2, Y_IMM}         y_sel_e;   // ALU Y operand

   typedef enum logic [1:0] {SZ_B, SZ_H, SZ_W} ls_size_e;    // Load/store access size

   // ------------------------------------
   // Memory-stage word held by exe_pipe
   // ig_type, pc, rd_wr, rd_addr, rd_data, ls_addr, st_data, size, mispre, mis
   // ------------------------------------
   localparam int EXE_OUT_W = 3 + PC_SZ + 1 + REG_ASZ + XLEN   // ig_type .. rd_data
                            + XLEN + XLEN + 2                  // ls_addr, st_data, size
                            + 1 + 1;                           // mispre, mis

endpackage

//--- src/operand_fwd.sv
// --------------------------------------
// Operand forwarding
// Picks Rs1/Rs2 values from MEM, WB or register read data
// --------------------------------------
`timescale 1ns/1ps

module operand_fwd import exe_pkg::*;
(
   input  logic [REG_ASZ-1:0] rs1_addr,
   input  logic [REG_ASZ-1:0] rs2_addr,
   input  logic               rs1_rd,            // Instruction really reads Rs1
   input  logic               rs2_rd,
   input  logic [XLEN-1:0]    rs1_data,          // From register file
   input  logic [XLEN-1:0]    rs2_data,

   input  logic               fwd_mem_valid,
   input  logic               fwd_mem_rd_wr,
   input  logic [REG_ASZ-1:0] fwd_mem_rd_addr,
   input  logic [XLEN-1:0]    fwd_mem_rd_data,

   input  logic               fwd_wb_valid,
   input  logic               fwd_wb_rd_wr,
   input  logic [REG_ASZ-1:0] fwd_wb_rd_addr,
   input  logic [XLEN-1:0]    fwd_wb_rd_data,

   output logic [XLEN-1:0]    rs1_val,
   output logic [XLEN-1:0]    rs2_val
);

   // Newest value wins, MEM is younger than WB
   function automatic logic [XLEN-1:0] pick
   (
      input logic [REG_ASZ-1:0] addr,
      input logic               rd,
      input logic [XLEN-1:0]    reg_data
   );
      logic use_mem;
      logic use_wb;
      use_mem = rd & fwd_mem_valid & fwd_mem_rd_wr & (addr == fwd_mem_rd_addr) & (addr != '0);
      use_wb  = rd & fwd_wb_valid  & fwd_wb_rd_wr  & (addr == fwd_wb_rd_addr)  & (addr != '0);
      if (use_mem)
         return fwd_mem_rd_data;
      else if (use_wb)
         return fwd_wb_rd_data;
      else
         return reg_data;                        // x0 always lands here
   endfunction

   assign rs1_val = pick(rs1_addr, rs1_rd, rs1_data);
   assign rs2_val = pick(rs2_addr, rs2_rd, rs2_data);

endmodule

//--- src/alu_unit.sv
// --------------------------------------
// Integer ALU for RV32I
// Add/sub, logic, shifts and set-less-than
// --------------------------------------
`timescale 1ns/1ps

module alu_unit import exe_pkg::*;
(
   input  alu_op_e           op,
   input  x_sel_e            x_sel,
   input  y_sel_e            y_sel,
   input  logic [XLEN-1:0]   rs1_val,
   input  logic [XLEN-1:0]   rs2_val,
   input  logic [PC_SZ-1:0]  pc,
   input  logic [XLEN-1:0]   imm,
   output logic [XLEN-1:0]   result
);

   logic [XLEN-1:0] x;
   logic [XLEN-1:0] y;
   logic [4:0]      shamt;

   // X operand, AUIPC uses pc and LUI uses zero
   always_comb
   begin
      case (x_sel)
         X_PC:    x = pc;
         X_ZERO:  x = '0;
         default: x = rs1_val;
      endcase
   end

   assign y     = (y_sel == Y_IMM) ? imm : rs2_val;
   assign shamt = y[4:0];                        // Only low 5 bits shift

   always_comb
   begin
      case (op)
         ADD:     result = x + y;
         SUB:     result = x - y;
         AND:     result = x & y;
         OR:      result = x | y;
         XOR:     result = x ^ y;
         SLL:     result = x << shamt;
         SRL:     result = x >> shamt;
         SRA:     result = $signed(x) >>> shamt;
         SLT:     result = {{(XLEN-1){1'b0}}, ($signed(x) < $signed(y))};
         SLTU:    result = {{(XLEN-1){1'b0}}, (x < y)};
         default: result = '0;
      endcase
   end

endmodule

//--- src/branch_unit.sv
// --------------------------------------
// Branch/jump resolution
// Taken condition, next PC, link address and target alignment
// --------------------------------------
`timescale 1ns/1ps

module branch_unit import exe_pkg::*;
(
   input  br_op_e            op,
   input  logic [XLEN-1:0]   rs1_val,
   input  logic [XLEN-1:0]   rs2_val,
   input  logic [PC_SZ-1:0]  pc,
   input  logic [XLEN-1:0]   imm,
   output logic [PC_SZ-1:0]  next_pc,           // Resolved address of next instruction
   output logic [PC_SZ-1:0]  link_pc,           // Return address for JAL/JALR
   output logic              mis                // Taken target not 4-byte aligned
);

   logic             taken;
   logic             eq;
   logic             lt;
   logic             ltu;
   logic [PC_SZ-1:0] target;
   logic [PC_SZ-1:0] jalr_sum;

   assign eq  = (rs1_val == rs2_val);
   assign lt  = ($signed(rs1_val) < $signed(rs2_val));
   assign ltu = (rs1_val < rs2_val);

   always_comb
   begin
      case (op)
         BEQ:     taken = eq;
         BNE:     taken = ~eq;
         BLT:     taken = lt;
         BGE:     taken = ~lt;
         BLTU:    taken = ltu;
         BGEU:    taken = ~ltu;
         default: taken = 1'b1;                  // JAL, JALR are unconditional
      endcase
   end

   // ------------------------------------
   // Target and next PC
   // ------------------------------------
   assign jalr_sum = rs1_val + imm;
   assign target   = (op == JALR) ? {jalr_sum[PC_SZ-1:1], 1'b0}  // Bit 0 dropped per spec
                                  : pc + imm;

   assign link_pc  = pc + 32'd4;
   assign next_pc  = taken ? target : link_pc;  // Fall through is also pc+4

   assign mis      = taken & (target[1:0] != 2'b00);

endmodule

//--- src/exe_pipe.sv
// --------------------------------------
// One-entry pipe register
// Holds one word between execute and memory stage
// --------------------------------------
`timescale 1ns/1ps

module exe_pipe
#(
   parameter int W = 32
)
(
   input  logic         clk_in,
   input  logic         arst_n,
   input  logic         flush,                   // Drop the held entry
   input  logic         write,                   // Load data_in
   input  logic [W-1:0] data_in,
   input  logic         read,                    // Consumer pops the entry
   output logic         full,
   output logic [W-1:0] data_out
);

   // Full flag, flush beats everything
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         full <= 1'b0;
      else if (flush)
         full <= 1'b0;
      else if (write)
         full <= 1'b1;                           // Also covers pop and refill in one cycle
      else if (read)
         full <= 1'b0;
   end

   // Payload register
   always_ff @(posedge clk_in)
   begin
      if (write)
         data_out <= data_in;
   end

   // Producer must never overwrite an entry that is not being popped
   a_no_overwrite: assert property (@(posedge clk_in) disable iff (!arst_n)
      !(write && full && !read))
      else $error("exe_pipe written while full and not read");

endmodule

//--- src/execute.sv
// --------------------------------------
// Execute stage top
// Forwarding, ALU, branch resolve, load/store address, pipe to MEM
// --------------------------------------
`timescale 1ns/1ps

module execute import exe_pkg::*;
(
   input  logic               clk_in,
   input  logic               arst_n,

   input  logic               pipe_flush,       // From hazard logic

   // Decode to execute
   input  logic               d2e_valid,
   output logic               d2e_ready,
   input  logic [PC_SZ-1:0]   pc,
   input  ig_type_e           ig_type,
   input  logic [OP_SZ-1:0]   op,               // alu_op_e, br_op_e or ls_size_e by group
   input  x_sel_e             x_sel,
   input  y_sel_e             y_sel,
   input  logic [XLEN-1:0]    imm,
   input  logic [REG_ASZ-1:0] rd_addr,
   input  logic               rd_wr,
   input  logic [REG_ASZ-1:0] rs1_addr,
   input  logic [REG_ASZ-1:0] rs2_addr,
   input  logic               rs1_rd,
   input  logic               rs2_rd,
   input  logic [XLEN-1:0]    rs1_data,
   input  logic [XLEN-1:0]    rs2_data,
   input  logic [PC_SZ-1:0]   predicted_addr,   // Where fetch went after this one

   // Forwarding from MEM and WB
   input  logic               fwd_mem_valid,
   input  logic               fwd_mem_rd_wr,
   input  logic [REG_ASZ-1:0] fwd_mem_rd_addr,
   input  logic [XLEN-1:0]    fwd_mem_rd_data,
   input  logic               fwd_wb_valid,
   input  logic               fwd_wb_rd_wr,
   input  logic [REG_ASZ-1:0] fwd_wb_rd_addr,
   input  logic [XLEN-1:0]    fwd_wb_rd_data,

   // Execute to memory
   output logic               e2m_valid,
   input  logic               e2m_ready,
   output ig_type_e           e2m_ig_type,
   output logic [PC_SZ-1:0]   e2m_pc,
   output logic               e2m_rd_wr,
   output logic [REG_ASZ-1:0] e2m_rd_addr,
   output logic [XLEN-1:0]    e2m_rd_data,
   output logic [XLEN-1:0]    e2m_ls_addr,
   output logic [XLEN-1:0]    e2m_st_data,
   output ls_size_e           e2m_size,
   output logic               e2m_mispre,
   output logic               e2m_mis,

   // PC reload to fetch
   output logic               rld_pc_flag,
   output logic [PC_SZ-1:0]   rld_pc_addr
);

   logic                 xfer_in;
   logic                 xfer_out;
   logic                 pipe_full;
   logic [XLEN-1:0]      rs1_val;
   logic [XLEN-1:0]      rs2_val;
   logic [XLEN-1:0]      alu_result;
   logic [PC_SZ-1:0]     br_next_pc;
   logic [PC_SZ-1:0]     br_link_pc;
   logic                 br_mis;
   logic                 br_mispre;
   logic [XLEN-1:0]      ls_addr;
   ls_size_e             ls_size;
   logic                 ls_mis;
   logic                 res_rd_wr;
   logic [XLEN-1:0]      res_rd_data;
   logic                 res_mis;
   logic [EXE_OUT_W-1:0] pipe_din;
   logic [EXE_OUT_W-1:0] pipe_dout;
   logic [2:0]           out_ig;
   logic [1:0]           out_size;

   // ------------------------------------
   // Handshakes
   // ------------------------------------
   assign xfer_out  = e2m_valid & e2m_ready;
   assign d2e_ready = ~pipe_flush & (~pipe_full | xfer_out);  // Empty or draining this cycle
   assign xfer_in   = d2e_valid & d2e_ready;

   operand_fwd u_fwd
   (
      .rs1_addr(rs1_addr),           .rs2_addr(rs2_addr),
      .rs1_rd(rs1_rd),               .rs2_rd(rs2_rd),
      .rs1_data(rs1_data),           .rs2_data(rs2_data),
      .fwd_mem_valid(fwd_mem_valid), .fwd_mem_rd_wr(fwd_mem_rd_wr),
      .fwd_mem_rd_addr(fwd_mem_rd_addr), .fwd_mem_rd_data(fwd_mem_rd_data),
      .fwd_wb_valid(fwd_wb_valid),   .fwd_wb_rd_wr(fwd_wb_rd_wr),
      .fwd_wb_rd_addr(fwd_wb_rd_addr), .fwd_wb_rd_data(fwd_wb_rd_data),
      .rs1_val(rs1_val),             .rs2_val(rs2_val)
   );

   alu_unit u_alu
   (
      .op(alu_op_e'(op)), .x_sel(x_sel), .y_sel(y_sel),
      .rs1_val(rs1_val), .rs2_val(rs2_val), .pc(pc), .imm(imm),
      .result(alu_result)
   );

   branch_unit u_br
   (
      .op(br_op_e'(op[2:0])), .rs1_val(rs1_val), .rs2_val(rs2_val),
      .pc(pc), .imm(imm),
      .next_pc(br_next_pc), .link_pc(br_link_pc), .mis(br_mis)
   );

   // Load/store address generation
   assign ls_addr   = rs1_val + imm;
   assign ls_size   = ls_size_e'(op[1:0]);
   assign ls_mis    = ((ls_size == SZ_H) & ls_addr[0])
                    | ((ls_size == SZ_W) & (ls_addr[1:0] != 2'b00));

   assign br_mispre = (ig_type == IG_BR) & (predicted_addr != br_next_pc);

   // ------------------------------------
   // Result select by instruction group
   // ------------------------------------
   always_comb
   begin
      res_rd_wr   = 1'b0;
      res_rd_data = '0;
      res_mis     = 1'b0;
      case (ig_type)
         IG_ALU:
         begin
            res_rd_wr   = rd_wr;
            res_rd_data = alu_result;
         end
         IG_BR:
         begin
            res_mis = br_mis;
            // Jumps link only if fetch already went the right way
            if ((op[2:0] == JAL || op[2:0] == JALR) && !br_mispre)
            begin
               res_rd_wr   = rd_wr;
               res_rd_data = br_link_pc;
            end
         end
         IG_LD:
         begin
            res_rd_wr = rd_wr;                   // Data arrives in MEM
            res_mis   = ls_mis;
         end
         IG_ST:   res_mis = ls_mis;
         default: res_mis = 1'b1;                // IG_ILL and unused codes trap later
      endcase
   end

   assign rld_pc_flag = xfer_in & br_mispre;
   assign rld_pc_addr = br_next_pc;

   assign pipe_din = {ig_type, pc,
                      res_rd_wr & (rd_addr != '0), rd_addr, res_rd_data,
                      ((ig_type == IG_LD) || (ig_type == IG_ST)) ? ls_addr : '0,
                      (ig_type == IG_ST) ? rs2_val : '0,
                      ((ig_type == IG_LD) || (ig_type == IG_ST)) ? op[1:0] : 2'b00,
                      br_mispre, res_mis};

   exe_pipe #(.W(EXE_OUT_W)) u_pipe
   (
      .clk_in(clk_in), .arst_n(arst_n), .flush(pipe_flush),
      .write(xfer_in), .data_in(pipe_din),
      .read(xfer_out), .full(pipe_full), .data_out(pipe_dout)
   );

   assign e2m_valid = pipe_full;
   assign {out_ig, e2m_pc, e2m_rd_wr, e2m_rd_addr, e2m_rd_data,
           e2m_ls_addr, e2m_st_data, out_size, e2m_mispre, e2m_mis} = pipe_dout;
   assign e2m_ig_type = ig_type_e'(out_ig);
   assign e2m_size    = ls_size_e'(out_size);

   // A reload only comes with an accepted branch, which shows up as mispredicted next cycle
   a_rld_xfer: assert property (@(posedge clk_in) disable iff (!arst_n)
      rld_pc_flag |=> (e2m_valid && e2m_mispre && (e2m_pc == $past(pc))))
      else $error("rld_pc_flag without matching decode transfer");

endmodule

//--- testbench/tb_tasks.svh
// --------------------------------------
// Execute stage directed tests
// Reference models and checks on the memory-side outputs
// --------------------------------------
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// RV32I integer ops, shifts use the low 5 bits of Y
function automatic logic [XLEN-1:0] alu_model(input logic [3:0] op_v,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
   logic [4:0] sh;
   sh = b[4:0];
   case (alu_op_e'(op_v))
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << sh;
      SRL:     return a >> sh;
      SRA:     return $unsigned($signed(a) >>> sh);
      SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTU:    return (a < b) ? 32'd1 : 32'd0;
      default: return 32'd0;
   endcase
endfunction

task automatic test_alu();
   logic [XLEN-1:0]  xv;
   logic [XLEN-1:0]  yv;
   logic [XLEN-1:0]  exp_v;
   logic             rf;
   logic [PC_SZ-1:0] ra;
   n_tests++;
   for (int k = 0; k < 10; k++)
      for (int xs = 0; xs < 3; xs++)
         for (int ys = 0; ys < 2; ys++)
         begin
            clear_fields();
            op       = 4'(k);
            x_sel    = x_sel_e'(xs[1:0]);
            y_sel    = y_sel_e'(ys[0]);
            pc       = next_rand() & ~32'h3;
            rs1_data = next_rand();
            rs2_data = next_rand();
            imm      = next_rand();
            rd_addr  = 5'd3;
            xv       = (x_sel == X_PC) ? pc : ((x_sel == X_ZERO) ? 32'd0 : rs1_data);
            yv       = (y_sel == Y_IMM) ? imm : rs2_data;
            exp_v    = alu_model(op, xv, yv);
            send_instr(rf, ra);
            if (e2m_rd_data !== exp_v)
               report_err("e2m_rd_data", exp_v, e2m_rd_data);
            if (e2m_rd_wr !== 1'b1)
               report_err("e2m_rd_wr", 32'd1, 32'(e2m_rd_wr));
         end
   clear_fields();                                 // Writes to x0 are dropped
   rs1_data = next_rand();
   rd_addr  = 5'd0;
   send_instr(rf, ra);
   if (e2m_rd_wr !== 1'b0)
      report_err("e2m_rd_wr", 32'd0, 32'(e2m_rd_wr));
endtask

// ------------------------------------
// Forwarding, Rs1 + imm 0 shows the chosen operand
// which: 0 register data, 1 MEM, 2 WB
// ------------------------------------
task automatic fwd_case(input logic [4:0] src, input logic rd, input logic [4:0] mem_a,
                        input logic [4:0] wb_a, input int which);
   logic [XLEN-1:0]  exp_v;
   logic             rf;
   logic [PC_SZ-1:0] ra;
   clear_fields();
   rs1_addr        = src;
   rs1_rd          = rd;
   rs1_data        = next_rand();
   y_sel           = Y_IMM;
   fwd_mem_valid   = 1'b1;
   fwd_mem_rd_wr   = 1'b1;
   fwd_mem_rd_addr = mem_a;
   fwd_mem_rd_data = next_rand();
   fwd_wb_valid    = 1'b1;
   fwd_wb_rd_wr    = 1'b1;
   fwd_wb_rd_addr  = wb_a;
   fwd_wb_rd_data  = next_rand();
   exp_v = (which == 1) ? fwd_mem_rd_data : ((which == 2) ? fwd_wb_rd_data : rs1_data);
   send_instr(rf, ra);
   if (e2m_rd_data !== exp_v)
      report_err("e2m_rd_data", exp_v, e2m_rd_data);
endtask

task automatic test_forwarding();
   n_tests++;
   fwd_case(5'd5, 1'b1, 5'd5, 5'd5, 1);            // Both match, MEM is newer
   fwd_case(5'd5, 1'b1, 5'd6, 5'd5, 2);            // Only WB
   fwd_case(5'd0, 1'b1, 5'd0, 5'd0, 0);            // x0 never forwarded
   fwd_case(5'd5, 1'b0, 5'd5, 5'd5, 0);            // Rs1 not read
   fwd_case(5'd5, 1'b1, 5'd6, 5'd7, 0);
endtask

// Each condition taken and not taken, jumps predicted right and wrong
task automatic test_branches();
   logic [XLEN-1:0]  neg_v;
   logic [XLEN-1:0]  pos_v;
   logic             swap;
   logic             jump;
   logic             cond;
   logic             exp_mp;
   logic [PC_SZ-1:0] exp_next;
   logic             rf;
   logic [PC_SZ-1:0] ra;
   n_tests++;
   for (int b = 0; b < 8; b++)
      for (int t = 0; t < 2; t++)
      begin
         clear_fields();
         ig_type  = IG_BR;
         op       = 4'(b);
         jump     = (b >= 6);
         neg_v    = next_rand() | 32'h8000_0000;   // Negative, large unsigned
         pos_v    = next_rand() & 32'h7fff_fffc;
         pc       = next_rand() & ~32'h3;
         imm      = (next_rand() & 32'h0000_0ff0) + 32'd16;
         rd_addr  = 5'd9;
         rd_wr    = jump;
         rs1_data = neg_v;
         rs2_data = pos_v;
         swap     = 1'b0;
         case (br_op_e'(b[2:0]))
            BEQ:       rs2_data = t[0] ? neg_v : pos_v;
            BNE:       rs2_data = t[0] ? pos_v : neg_v;
            BLT:       swap = ~t[0];
            BGE, BLTU: swap = t[0];
            BGEU:      swap = ~t[0];
            default:   swap = 1'b1;                // Aligned base for JALR
         endcase
         if (swap)
         begin
            rs1_data = pos_v;
            rs2_data = neg_v;
         end
         cond     = jump | t[0];
         exp_next = !cond ? pc + 32'd4
                          : ((b == 7) ? ((rs1_data + imm) & ~32'h1) : pc + imm);
         exp_mp   = jump ? ~t[0] : t[0];           // Fetch assumed fall through
         predicted_addr = exp_mp ? (exp_next ^ 32'h100) : exp_next;
         send_instr(rf, ra);
         if (rf !== exp_mp)
            report_err("rld_pc_flag", 32'(exp_mp), 32'(rf));
         if (exp_mp && ra !== exp_next)
            report_err("rld_pc_addr", exp_next, ra);
         if (e2m_mispre !== exp_mp)
            report_err("e2m_mispre", 32'(exp_mp), 32'(e2m_mispre));
         if (e2m_mis !== 1'b0)
            report_err("e2m_mis", 32'd0, 32'(e2m_mis));
         if (e2m_rd_wr !== (jump & ~exp_mp))
            report_err("e2m_rd_wr", 32'(jump & ~exp_mp), 32'(e2m_rd_wr));
         if (jump && !exp_mp && e2m_rd_data !== pc + 32'd4)
            report_err("e2m_rd_data", pc + 32'd4, e2m_rd_data);
      end
endtask

// Every size at every byte offset, as load and as store
task automatic test_load_store();
   logic [XLEN-1:0]  exp_addr;
   logic             exp_mis;
   logic             rf;
   logic [PC_SZ-1:0] ra;
   n_tests++;
   for (int s = 0; s < 3; s++)
      for (int off = 0; off < 4; off++)
         for (int st = 0; st < 2; st++)
         begin
            clear_fields();
            ig_type  = (st == 1) ? IG_ST : IG_LD;
            op       = 4'(s);
            rs1_data = next_rand() & ~32'h3;
            rs2_data = next_rand();
            imm      = (next_rand() & 32'h0000_07f0) + 32'(off);
            rd_addr  = 5'd12;
            rd_wr    = (st == 0);
            exp_addr = rs1_data + imm;
            exp_mis  = (s == 1) ? off[0] : ((s == 2) ? (off != 0) : 1'b0);
            send_instr(rf, ra);
            if (e2m_ls_addr !== exp_addr)
               report_err("e2m_ls_addr", exp_addr, e2m_ls_addr);
            if (e2m_size !== ls_size_e'(s[1:0]))
               report_err("e2m_size", 32'(s), 32'(e2m_size));
            if (e2m_mis !== exp_mis)
               report_err("e2m_mis", 32'(exp_mis), 32'(e2m_mis));
            if (e2m_rd_wr !== (st == 0))
               report_err("e2m_rd_wr", 32'(st == 0), 32'(e2m_rd_wr));
            if (st == 1 && e2m_st_data !== rs2_data)
               report_err("e2m_st_data", rs2_data, e2m_st_data);
         end
endtask

// ------------------------------------
// Stall with e2m_ready low, then drain, then flush
// ------------------------------------
task automatic test_backpressure();
   logic [XLEN-1:0]  a_v;
   logic [XLEN-1:0]  b_v;
   logic             rf;
   logic [PC_SZ-1:0] ra;
   n_tests++;
   @(negedge clk_in);                              // Last load/store leaves the pipe
   e2m_ready = 1'b0;
   clear_fields();
   rs1_data = next_rand();                         // ADD with zero Rs2 returns Rs1
   a_v      = rs1_data;
   send_instr(rf, ra);                             // A fills the empty pipe
   clear_fields();
   rs1_data  = next_rand();
   b_v       = rs1_data;
   d2e_valid = 1'b1;                               // B waits behind A
   repeat (3)
   begin
      #1;
      if (d2e_ready !== 1'b0)
         report_err("d2e_ready", 32'd0, 32'(d2e_ready));
      if (e2m_rd_data !== a_v)
         report_err("e2m_rd_data", a_v, e2m_rd_data);
      @(negedge clk_in);
   end
   e2m_ready = 1'b1;                               // Pop A and load B on one edge
   #1;
   if (d2e_ready !== 1'b1)
      report_err("d2e_ready", 32'd1, 32'(d2e_ready));
   @(negedge clk_in);
   d2e_valid = 1'b0;
   if (e2m_valid !== 1'b1)
      $display("Error at %0t ns: instruction B was lost after the stall", $time);
   if (e2m_valid !== 1'b1)
      n_errors++;
   if (e2m_rd_data !== b_v)
      report_err("e2m_rd_data", b_v, e2m_rd_data);
   @(negedge clk_in);
   if (e2m_valid !== 1'b0)
      report_err("e2m_valid", 32'd0, 32'(e2m_valid));

   e2m_ready = 1'b0;
   clear_fields();
   rs1_data = next_rand();
   send_instr(rf, ra);                             // C held in the pipe
   pipe_flush = 1'b1;
   @(negedge clk_in);
   pipe_flush = 1'b0;
   if (e2m_valid !== 1'b0)
      report_err("e2m_valid", 32'd0, 32'(e2m_valid));

   // Empty pipe with MEM ready, only the flush holds D back
   e2m_ready = 1'b1;
   clear_fields();
   d2e_valid  = 1'b1;
   pipe_flush = 1'b1;
   #1;
   if (d2e_ready !== 1'b0)
      report_err("d2e_ready", 32'd0, 32'(d2e_ready));
   @(negedge clk_in);
   pipe_flush = 1'b0;
   d2e_valid  = 1'b0;
   if (e2m_valid !== 1'b0)
      report_err("e2m_valid", 32'd0, 32'(e2m_valid));
endtask

`endif

//--- testbench/tb_execute.sv
// --------------------------------------
// Execute stage testbench
// Clock, reset, DUT, random source and test sequence
// --------------------------------------
`timescale 1ns/1ps

module tb_execute
   import exe_pkg::*;
();

   localparam int RST_CYCLES = 8;
   // Each instruction takes about one clock, with margin for stalls
   localparam int TEST_CYCLES = RST_CYCLES + 2 + (10 * 3 * 2 + 1) + 5 + 16 + 24 + 12;
   localparam int MAX_CYCLES  = 4 * TEST_CYCLES;

   logic               clk_in = 1'b0;
   logic               arst_n;
   logic               pipe_flush;
   logic               d2e_valid;
   logic               d2e_ready;
   logic [PC_SZ-1:0]   pc;
   ig_type_e           ig_type;
   logic [OP_SZ-1:0]   op;
   x_sel_e             x_sel;
   y_sel_e             y_sel;
   logic [XLEN-1:0]    imm;
   logic [REG_ASZ-1:0] rd_addr;
   logic               rd_wr;
   logic [REG_ASZ-1:0] rs1_addr;
   logic [REG_ASZ-1:0] rs2_addr;
   logic               rs1_rd;
   logic               rs2_rd;
   logic [XLEN-1:0]    rs1_data;
   logic [XLEN-1:0]    rs2_data;
   logic [PC_SZ-1:0]   predicted_addr;
   logic               fwd_mem_valid;
   logic               fwd_mem_rd_wr;
   logic [REG_ASZ-1:0] fwd_mem_rd_addr;
   logic [XLEN-1:0]    fwd_mem_rd_data;
   logic               fwd_wb_valid;
   logic               fwd_wb_rd_wr;
   logic [REG_ASZ-1:0] fwd_wb_rd_addr;
   logic [XLEN-1:0]    fwd_wb_rd_data;
   logic               e2m_valid;
   logic               e2m_ready;
   ig_type_e           e2m_ig_type;
   logic [PC_SZ-1:0]   e2m_pc;
   logic               e2m_rd_wr;
   logic [REG_ASZ-1:0] e2m_rd_addr;
   logic [XLEN-1:0]    e2m_rd_data;
   logic [XLEN-1:0]    e2m_ls_addr;
   logic [XLEN-1:0]    e2m_st_data;
   ls_size_e           e2m_size;
   logic               e2m_mispre;
   logic               e2m_mis;
   logic               rld_pc_flag;
   logic [PC_SZ-1:0]   rld_pc_addr;

   logic [31:0] seed = 32'h5873_a8be;              // LCG state
   int          n_errors = 0;
   int          n_tests  = 0;
   int          cycles   = 0;

   always #5 clk_in = ~clk_in;                     // 10 ns period

   execute execute_i (.*);

   // ------------------------------------
   // Timeout guard
   // ------------------------------------
   always @(posedge clk_in)
   begin
      cycles++;
      if (cycles > MAX_CYCLES)
      begin
         $display("Timeout: run still busy after %0d cycles, %0d errors so far",
                  MAX_CYCLES, n_errors);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // Numerical Recipes LCG
   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic report_err(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
      n_errors++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
   endtask

   // Benign ALU ADD x1 = x1 + x2 with no forwarding
   task automatic clear_fields();
      pc              = '0;
      ig_type         = IG_ALU;
      op              = '0;
      x_sel           = X_RS1;
      y_sel           = Y_RS2;
      imm             = '0;
      rd_addr         = 5'd1;
      rd_wr           = 1'b1;
      rs1_addr        = 5'd1;
      rs2_addr        = 5'd2;
      rs1_rd          = 1'b1;
      rs2_rd          = 1'b1;
      rs1_data        = '0;
      rs2_data        = '0;
      predicted_addr  = '0;
      fwd_mem_valid   = 1'b0;
      fwd_mem_rd_wr   = 1'b0;
      fwd_mem_rd_addr = '0;
      fwd_mem_rd_data = '0;
      fwd_wb_valid    = 1'b0;
      fwd_wb_rd_wr    = 1'b0;
      fwd_wb_rd_addr  = '0;
      fwd_wb_rd_data  = '0;
   endtask

   // Offer the fields at this falling edge, wait for the transfer, return at the next one
   task automatic send_instr(output logic rld_f, output logic [PC_SZ-1:0] rld_a);
      d2e_valid = 1'b1;
      #1;
      while (d2e_ready !== 1'b1)
      begin
         @(negedge clk_in);
         #1;
      end
      rld_f = rld_pc_flag;                         // Reload is combinational with the transfer
      rld_a = rld_pc_addr;
      @(negedge clk_in);
      d2e_valid = 1'b0;
      if (e2m_valid !== 1'b1)                      // One cycle latency
         report_err("e2m_valid", 32'd1, 32'(e2m_valid));
      // Fields that pass straight through to MEM
      if (e2m_ig_type !== ig_type)
         report_err("e2m_ig_type", 32'(ig_type), 32'(e2m_ig_type));
      if (e2m_pc !== pc)
         report_err("e2m_pc", pc, e2m_pc);
      if (e2m_rd_addr !== rd_addr)
         report_err("e2m_rd_addr", 32'(rd_addr), 32'(e2m_rd_addr));
   endtask

   `include "tb_tasks.svh"

   initial
   begin
      clear_fields();
      d2e_valid  = 1'b0;
      e2m_ready  = 1'b1;
      pipe_flush = 1'b0;
      arst_n     = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_in);
      @(negedge clk_in);
      arst_n = 1'b1;
      if (e2m_valid !== 1'b0)
         report_err("e2m_valid", 32'd0, 32'(e2m_valid));
      @(negedge clk_in);

      test_alu();
      test_forwarding();
      test_branches();
      test_load_store();
      test_backpressure();

      $display("Tests run: %0d, errors: %0d", n_tests, n_errors);
      if (n_errors == 0)
      begin
         $display("NO ERRORS");
      end
      else
      begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- sources.f
+incdir+testbench
src/exe_pkg.sv
src/operand_fwd.sv
src/alu_unit.sv
src/branch_unit.sv
src/exe_pipe.sv
src/execute.sv
testbench/tb_execute.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_execute
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(wildcard src/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) sources.f
	$(VERILATOR) $(VFLAGS) -f sources.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
